//--- hw/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width
`define EXEC_RV 32

`define EXEC_NREG 16

// reads the high half of the mul/div result
`define EXEC_MD_REG 7

`define EXEC_SHW 5

`endif

//--- hw/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

	typedef logic [`EXEC_RV-1:0] word_t;

	typedef logic [$clog2(`EXEC_NREG)-1:0] reg_idx_t;

	typedef logic [`EXEC_RV/8-1:0] mask_t;	// one bit per byte lane

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_XOR   = 4'd2,
		OP_OR    = 4'd3,
		OP_AND   = 4'd4,
		OP_SLL   = 4'd5,
		OP_SRA   = 4'd6,
		OP_SRL   = 4'd7,
		OP_ADDB  = 4'd8,
		OP_ADDBU = 4'd9,
		OP_SWAP  = 4'd10
	} alu_op_t;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/1ps

`include "exec_cfg.svh"

module reg_file import exec_pkg::*; (
	input  logic     clk,
	input  logic     wb_valid,
	input  reg_idx_t wb_addr,
	input  word_t    wb_data,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  word_t    md_hi,
	output word_t    rs1_val,
	output word_t    rs2_val
);

	localparam reg_idx_t MD_IDX = reg_idx_t'(`EXEC_MD_REG);

	// slot for the mul/div register is never written
	word_t regs [1:`EXEC_NREG-1];

	logic wr_en;

	assign wr_en = wb_valid && wb_addr != '0 && wb_addr != MD_IDX;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// pending writeback wins over the stored value
	function automatic word_t read_port(input reg_idx_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wb_valid && wb_addr == idx) begin
			val = wb_data;
		end else if (idx == MD_IDX) begin
			val = md_hi;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_comb begin
		rs1_val = read_port(rs1);
	end

	always_comb begin
		rs2_val = read_port(rs2);
	end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

`include "exec_cfg.svh"

module alu import exec_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result
);

	word_t sum;
	word_t diff;
	logic [`EXEC_SHW-1:0] shamt;

	assign sum = a + b;
	assign diff = a - b;
	assign shamt = b[`EXEC_SHW-1:0];

	always_comb begin
		case (op)
			OP_ADD:   result = sum;
			OP_SUB:   result = diff;
			OP_XOR:   result = a ^ b;
			OP_OR:    result = a | b;
			OP_AND:   result = a & b;
			OP_SLL:   result = a << shamt;
			OP_SRA:   result = word_t'($signed(a) >>> shamt);
			OP_SRL:   result = a >> shamt;
			OP_ADDB:  result = {{(`EXEC_RV-8){sum[7]}}, sum[7:0]};	// sign extend low byte
			OP_ADDBU: result = {{(`EXEC_RV-8){1'b0}}, sum[7:0]};
			OP_SWAP:  result = {{(`EXEC_RV-16){1'b0}}, b[7:0], b[15:8]};
			default:  result = '0;	// unassigned opcodes
		endcase
	end

endmodule

//--- hw/mul_div.sv
`timescale 1ns/1ps

`include "exec_cfg.svh"

module mul_div import exec_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  start_mult,
	input  logic  start_div,
	input  word_t a,
	input  word_t b,
	input  logic  hi_write,
	input  word_t hi_data,
	output logic  md_busy,
	output logic  md_done,
	output word_t md_lo,
	output word_t md_hi
);

	localparam int RV = `EXEC_RV;
	localparam int CW = $clog2(RV);

	logic [CW-1:0] bit_off;
	logic is_div;
	word_t divisor;
	logic [2*RV-1:0] res;	// {hi, lo}
	logic [RV:0] mul_sum;
	logic [RV:0] div_top;
	logic [RV+1:0] div_diff;
	logic start;

	assign start = start_mult || start_div;

	// multiply shifts right, adding into the top half
	assign mul_sum = {1'b0, res[2*RV-1:RV]} + (res[0] ? {1'b0, divisor} : '0);

	// restoring divide, partial remainder with next dividend bit
	assign div_top = res[2*RV-1:RV-1];
	assign div_diff = {1'b0, div_top} - {2'b0, divisor};

	assign md_lo = res[RV-1:0];
	assign md_hi = res[2*RV-1:RV];

	always_ff @(posedge clk) begin
		if (reset) begin
			md_busy <= 1'b0;
			md_done <= 1'b0;
			bit_off <= '0;
			is_div <= 1'b0;
		end else begin
			md_done <= md_busy && bit_off == '0;
			if (start) begin
				md_busy <= 1'b1;
				bit_off <= CW'(RV-1);
				is_div <= start_div;
			end else if (md_busy) begin
				bit_off <= bit_off - 1'b1;
				if (bit_off == '0) begin
					md_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			res <= {{RV{1'b0}}, a};
			divisor <= b;
		end else if (hi_write) begin
			res[2*RV-1:RV] <= hi_data;
		end else if (md_busy) begin
			if (!is_div) begin
				res <= {mul_sum, res[RV-1:1]};
			end else if (divisor == '0) begin
				res <= '0;	// x/0 gives 0, remainder 0
			end else if (!div_diff[RV+1]) begin
				res <= {div_diff[RV-1:0], res[RV-2:0], 1'b1};
			end else begin
				res <= {div_top[RV-1:0], res[RV-2:0], 1'b0};
			end
		end
	end

	a_one_start: assert property (@(posedge clk) disable iff (reset)
		!(start_mult && start_div));

	// controller must hold off issue until the result is written back
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !md_busy && !md_done);

endmodule

//--- hw/issue_ctrl.sv
`timescale 1ns/1ps

`include "exec_cfg.svh"

module issue_ctrl import exec_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     issue,
	input  alu_op_t  op,
	input  reg_idx_t rd,
	input  logic     needs_rs2,
	input  word_t    imm,
	input  logic     mult,
	input  logic     div,
	input  logic     store,
	input  logic     byte_store,
	input  word_t    rs2_val,
	input  word_t    rs1_val,
	input  word_t    alu_result,
	input  logic     md_busy,
	input  logic     md_done,
	input  word_t    md_lo,
	input  logic     wdone,
	output logic     ready,
	output word_t    operand_b,
	output logic     start_mult,
	output logic     start_div,
	output logic     wb_valid,
	output reg_idx_t wb_addr,
	output word_t    wb_data,
	output logic     hi_write,
	output word_t    addr,
	output word_t    wdata,
	output mask_t    wmask
);

	localparam int BW = $clog2(`EXEC_RV/8);

	logic accept;
	logic alu_wb;
	logic store_go;
	reg_idx_t md_rd;
	word_t store_addr;

	// low during mul/div, its writeback cycle and a pending store
	assign ready = !md_busy && !md_done && wmask == '0;
	assign accept = issue && ready;

	assign operand_b = needs_rs2 ? rs2_val : imm;
	assign start_mult = accept && mult;
	assign start_div = accept && div;
	assign alu_wb = accept && !mult && !div && !store && op <= OP_SWAP;
	assign store_go = accept && store;
	assign store_addr = rs1_val + imm;

	assign hi_write = wb_valid && wb_addr == reg_idx_t'(`EXEC_MD_REG);

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= md_done || alu_wb;
		end
	end

	always_ff @(posedge clk) begin
		if (start_mult || start_div) begin
			md_rd <= rd;
		end
		if (md_done) begin	// mul/div result first
			wb_addr <= md_rd;
			wb_data <= md_lo;
		end else if (alu_wb) begin
			wb_addr <= rd;
			wb_data <= alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wmask <= '0;
		end else if (wmask != '0) begin
			if (wdone) begin
				wmask <= '0;
			end
		end else if (store_go) begin
			wmask <= byte_store ? mask_t'(1) << store_addr[BW-1:0] : '1;
		end
	end

	always_ff @(posedge clk) begin
		if (store_go) begin
			addr <= store_addr;
			wdata <= byte_store ? {(`EXEC_RV/8){rs2_val[7:0]}} : rs2_val;
		end
	end

	a_wmask_shape: assert property (@(posedge clk) disable iff (reset)
		$onehot0(wmask) || &wmask);

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_unit import exec_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     issue,
	input  alu_op_t  op,
	input  reg_idx_t rd,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  word_t    imm,
	input  logic     needs_rs2,
	input  logic     mult,
	input  logic     div,
	input  logic     store,
	input  logic     byte_store,
	output logic     ready,
	output word_t    addr,
	output word_t    wdata,
	output mask_t    wmask,
	input  logic     wdone
);

	word_t rs1_val;
	word_t rs2_val;
	word_t operand_b;
	word_t alu_result;
	logic start_mult;
	logic start_div;
	logic md_busy;
	logic md_done;
	word_t md_lo;
	word_t md_hi;
	logic hi_write;
	logic wb_valid;
	reg_idx_t wb_addr;
	word_t wb_data;

	reg_file reg_file_inst (
		.clk(clk),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.rs1(rs1),
		.rs2(rs2),
		.md_hi(md_hi),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val)
	);

	alu alu_inst (
		.op(op),
		.a(rs1_val),
		.b(operand_b),
		.result(alu_result)
	);

	mul_div mul_div_inst (
		.clk(clk),
		.reset(reset),
		.start_mult(start_mult),
		.start_div(start_div),
		.a(rs1_val),
		.b(operand_b),
		.hi_write(hi_write),
		.hi_data(wb_data),	// write to r7 lands in hi
		.md_busy(md_busy),
		.md_done(md_done),
		.md_lo(md_lo),
		.md_hi(md_hi)
	);

	issue_ctrl issue_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.op(op),
		.rd(rd),
		.needs_rs2(needs_rs2),
		.imm(imm),
		.mult(mult),
		.div(div),
		.store(store),
		.byte_store(byte_store),
		.rs2_val(rs2_val),
		.rs1_val(rs1_val),
		.alu_result(alu_result),
		.md_busy(md_busy),
		.md_done(md_done),
		.md_lo(md_lo),
		.wdone(wdone),
		.ready(ready),
		.operand_b(operand_b),
		.start_mult(start_mult),
		.start_div(start_div),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.hi_write(hi_write),
		.addr(addr),
		.wdata(wdata),
		.wmask(wmask)
	);

endmodule

//--- bench/exec_unit_tb.sv
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_unit_tb import exec_pkg::*; ();

	localparam int TIMEOUT = 200;
	localparam reg_idx_t MD_IDX = reg_idx_t'(`EXEC_MD_REG);

	logic clk;
	logic reset;
	logic issue;
	alu_op_t op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t imm;
	logic needs_rs2;
	logic mult;
	logic div;
	logic store;
	logic byte_store;
	logic ready;
	word_t addr;
	word_t wdata;
	mask_t wmask;
	logic wdone;

	int error_count = 0;
	int errors_at_start = 0;
	int test_count = 0;
	int fail_count = 0;

	// stores the checker still has to see
	string exp_name[$];
	word_t exp_data[$];
	word_t exp_addr[$];
	mask_t exp_mask[$];
	mask_t last_mask;
	string cur_name;

	exec_unit exec_unit_inst (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.op(op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm),
		.needs_rs2(needs_rs2),
		.mult(mult),
		.div(div),
		.store(store),
		.byte_store(byte_store),
		.ready(ready),
		.addr(addr),
		.wdata(wdata),
		.wmask(wmask),
		.wdone(wdone)
	);

	always #2 clk = ~clk;

	function automatic word_t ref_alu(input alu_op_t f, input word_t a, input word_t b);
		word_t s;
		int sh;
		s = a + b;
		sh = int'(b[`EXEC_SHW-1:0]);
		case (f)
			OP_ADD:   return s;
			OP_SUB:   return a - b;
			OP_XOR:   return a ^ b;
			OP_OR:    return a | b;
			OP_AND:   return a & b;
			OP_SLL:   return a << sh;
			OP_SRA:   return word_t'($signed(a) >>> sh);
			OP_SRL:   return a >> sh;
			OP_ADDB:  return {{24{s[7]}}, s[7:0]};
			OP_ADDBU: return {24'd0, s[7:0]};
			OP_SWAP:  return {16'd0, b[7:0], b[15:8]};
			default:  return '0;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic timeout_error(input string what);
		$display("timeout: %s", what);
		error_count++;
	endtask

	// each new store on the bus is checked against the oldest expectation
	always @(negedge clk) begin
		if (!reset && wmask != '0 && last_mask == '0) begin
			if (exp_name.size() == 0) begin
				$display("a store appeared on the bus that no test expected");
				error_count++;
			end else begin
				cur_name = exp_name.pop_front();
				compare({cur_name, " wdata"}, exp_data.pop_front(), wdata);
				compare({cur_name, " addr"}, exp_addr.pop_front(), addr);
				compare({cur_name, " wmask"}, 32'(exp_mask.pop_front()), 32'(wmask));
			end
		end
		last_mask = wmask;
	end

	task automatic expect_store(input string name, input word_t d, input word_t a, input mask_t m);
		exp_name.push_back(name);
		exp_data.push_back(d);
		exp_addr.push_back(a);
		exp_mask.push_back(m);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready && n < TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		if (!ready) begin
			timeout_error("ready stayed low");
		end
	endtask

	task automatic send(input alu_op_t f, input reg_idx_t d, input reg_idx_t s1,
			input reg_idx_t s2, input word_t im, input logic use_rs2, input logic m,
			input logic dv, input logic st, input logic bs);
		wait_ready();
		op = f;
		rd = d;
		rs1 = s1;
		rs2 = s2;
		imm = im;
		needs_rs2 = use_rs2;
		mult = m;
		div = dv;
		store = st;
		byte_store = bs;
		issue = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		mult = 1'b0;
		div = 1'b0;
		store = 1'b0;
		byte_store = 1'b0;
	endtask

	// holds wdone off for delay cycles, then answers
	task automatic complete_store(input string name, input int delay);
		int n;
		word_t held_data;
		word_t held_addr;
		mask_t held_mask;
		n = 0;
		while (wmask == '0 && n < TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		if (wmask == '0) begin
			timeout_error("store never appeared on the bus");
		end
		held_data = wdata;
		held_addr = addr;
		held_mask = wmask;
		repeat (delay) begin
			@(negedge clk);
			compare({name, " held wdata"}, held_data, wdata);
			compare({name, " held addr"}, held_addr, addr);
			compare({name, " held wmask"}, 32'(held_mask), 32'(wmask));
			compare({name, " ready while waiting"}, 32'd0, 32'(ready));
		end
		wdone = 1'b1;
		n = 0;
		@(negedge clk);
		while (wmask != '0 && n < TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		if (wmask != '0) begin
			timeout_error("wmask did not clear after wdone");
		end
		wdone = 1'b0;
	endtask

	task automatic load_reg(input reg_idx_t idx, input word_t val);
		send(OP_ADD, idx, 4'd0, 4'd0, val, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// word store of the register, rs1 = r0 so addr is the immediate
	task automatic read_reg(input string name, input reg_idx_t idx, input word_t exp);
		word_t where;
		where = $urandom;
		expect_store(name, exp, where, 4'hf);
		send(OP_ADD, 4'd0, 4'd0, idx, where, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		complete_store(name, 0);
	endtask

	task automatic end_test(input string name);
		int n;
		n = 0;
		while (exp_name.size() != 0 && n < TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		if (exp_name.size() != 0) begin
			timeout_error("an expected store never reached the bus");
		end
		test_count++;
		if (error_count == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d error(s)", name, error_count - errors_at_start);
			fail_count++;
		end
		errors_at_start = error_count;
	endtask

	initial begin
		word_t a;
		word_t b;
		word_t val;
		word_t im;
		logic [63:0] prod;
		alu_op_t f;
		reg_idx_t src;
		reg_idx_t dst;
		int k;
		int u;
		int delay;
		void'($urandom(32'h7dc67d69));
		clk = 1'b0;
		reset = 1'b1;
		issue = 1'b0;
		op = OP_ADD;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		imm = '0;
		needs_rs2 = 1'b0;
		mult = 1'b0;
		div = 1'b0;
		store = 1'b0;
		byte_store = 1'b0;
		wdone = 1'b0;
		last_mask = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		compare("reset wmask", 32'd0, 32'(wmask));
		compare("reset ready", 32'd1, 32'(ready));
		for (k = 0; k <= 10; k++) begin
			for (u = 0; u < 2; u++) begin
				f = alu_op_t'(k);
				a = $urandom;
				b = $urandom;
				load_reg(4'd1, a);
				load_reg(4'd2, b);
				// imm case points rs2 at r0 so the operand select matters
				send(f, 4'd3, 4'd1, u ? 4'd2 : 4'd0, u ? 32'd0 : b, u[0],
					1'b0, 1'b0, 1'b0, 1'b0);
				read_reg({"alu ", f.name(), u ? " rs2" : " imm"}, 4'd3, ref_alu(f, a, b));
			end
		end
		end_test("alu");

		val = $urandom;
		load_reg(4'd4, val);
		src = 4'd4;
		for (k = 0; k < 6; k++) begin
			dst = (k % 2 == 0) ? 4'd10 : 4'd11;	// each step reads the last rd
			f = alu_op_t'($urandom_range(0, 10));
			b = $urandom;
			send(f, dst, src, 4'd0, b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
			val = ref_alu(f, val, b);
			src = dst;
		end
		read_reg("forward chain", src, val);
		send(OP_ADD, 4'd0, 4'd4, 4'd0, 32'd5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		read_reg("r0 after write", 4'd0, 32'd0);
		end_test("forward");

		for (k = 0; k < 3; k++) begin
			a = $urandom;
			b = $urandom;
			load_reg(4'd1, a);
			load_reg(4'd2, b);
			send(OP_ADD, 4'd3, 4'd1, 4'd2, 32'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
			prod = {32'd0, a} * {32'd0, b};
			read_reg("mult low", 4'd3, prod[31:0]);
			read_reg("mult high", MD_IDX, prod[63:32]);
		end
		end_test("multiply");

		for (k = 0; k < 4; k++) begin
			a = $urandom;
			b = $urandom;
			b = b >> $urandom_range(4, 28);	// spread of quotient sizes
			if (k == 3) begin
				b = 32'd0;
			end
			load_reg(4'd1, a);
			load_reg(4'd2, b);
			send(OP_ADD, 4'd3, 4'd1, 4'd2, 32'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
			read_reg("div quotient", 4'd3, (b == 0) ? 32'd0 : a / b);
			read_reg("div remainder", MD_IDX, (b == 0) ? 32'd0 : a % b);
		end
		end_test("divide");

		for (k = 0; k < 4; k++) begin
			a = $urandom & 32'hffff_fffc;
			im = $urandom;
			im[1:0] = k[1:0];	// lane k
			val = $urandom;
			load_reg(4'd1, a);
			load_reg(4'd2, val);
			expect_store("byte store", {4{val[7:0]}}, a + im, mask_t'(1) << k);
			send(OP_ADD, 4'd0, 4'd1, 4'd2, im, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
			complete_store("byte store", 0);
		end
		end_test("byte store");

		for (k = 0; k < 4; k++) begin
			a = $urandom;
			im = $urandom;
			val = $urandom;
			delay = $urandom_range(1, 12);
			load_reg(4'd1, a);
			load_reg(4'd2, val);
			if (k % 2 == 0) begin
				expect_store("stalled word store", val, a + im, 4'hf);
				send(OP_ADD, 4'd0, 4'd1, 4'd2, im, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
			end else begin
				b = a + im;
				expect_store("stalled byte store", {4{val[7:0]}}, b, mask_t'(1) << b[1:0]);
				send(OP_ADD, 4'd0, 4'd1, 4'd2, im, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
			end
			complete_store("stalled store", delay);
			compare("ready after wdone", 32'd1, 32'(ready));
		end
		end_test("back-pressure");

		$display("%0d tests run, %0d failed, %0d errors", test_count, fail_count, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- exec_unit.f
+incdir+hw
hw/exec_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/mul_div.sv
hw/issue_ctrl.sv
hw/exec_unit.sv
bench/exec_unit_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module exec_unit_tb -f exec_unit.f -o exec_unit_sim

./obj_dir/exec_unit_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
